// ==== source/systolic_cfg.svh ====
`ifndef SYSTOLIC_CFG_SVH
`define SYSTOLIC_CFG_SVH

// grid is SYS_ARRAY_SIZE x SYS_ARRAY_SIZE cells
`define SYS_ARRAY_SIZE 4

`define SYS_DATA_WIDTH 8   // signed operand width
`define SYS_ACC_WIDTH  32  // per-cell accumulator

// external memory and output address width
`define SYS_ADDR_WIDTH 12

// entries per feed FIFO
`define SYS_FIFO_DEPTH 8

`endif

// ==== source/systolic_pkg.sv ====
`include "systolic_cfg.svh"

package systolic_pkg;

    typedef logic signed [`SYS_DATA_WIDTH-1:0] operand_t;

    // one memory word, element n feeds lane n
    typedef operand_t [`SYS_ARRAY_SIZE-1:0] row_t;

    typedef logic signed [`SYS_ACC_WIDTH-1:0] acc_t;

    // indexed [row][col]
    typedef acc_t [`SYS_ARRAY_SIZE-1:0][`SYS_ARRAY_SIZE-1:0] acc_grid_t;

    typedef enum logic [1:0] {
        IDLE,
        FILL,
        COMPUTE,
        WRITE_BACK
    } ctrl_state_t;

    typedef enum logic [2:0] {
        REG_W_BASE  = 3'd0,
        REG_I_BASE  = 3'd1,
        REG_K_DEPTH = 3'd2,
        REG_O_BASE  = 3'd3,
        REG_QSHIFT  = 3'd4,
        REG_CTRL    = 3'd5,  // bit 0 go
        REG_STATUS  = 3'd7   // bit 0 done, read only
    } reg_addr_t;

endpackage

// ==== source/array_ctrl_if.sv ====
interface array_ctrl_if;

    logic                    clr;        // clears accumulators and mac count
    logic                    run;        // lets the array pop the feed FIFOs
    logic [7:0]              k_depth;    // macs expected per cell
    logic [7:0]              mac_count;  // macs done by the bottom-right cell
    systolic_pkg::acc_grid_t results;

    modport ctrl (
        output clr,
        output run,
        output k_depth,
        input  mac_count,
        input  results
    );

    modport array (
        input  clr,
        input  run,
        input  k_depth,
        output mac_count,
        output results
    );

endinterface

// ==== source/config_regs.sv ====
module config_regs (
    input  logic                    clk,
    input  logic                    rst_n,
    input  systolic_pkg::reg_addr_t reg_addr,
    input  logic                    reg_wr,
    input  logic [7:0]              reg_wdata,
    input  logic                    run_done,
    output logic [7:0]              reg_rdata,
    output logic                    go,
    output logic [7:0]              w_base,
    output logic [7:0]              i_base,
    output logic [7:0]              o_base,
    output logic [7:0]              k_depth,
    output logic [7:0]              qshift
);

    logic done;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            w_base  <= '0;
            i_base  <= '0;
            o_base  <= '0;
            k_depth <= '0;
            qshift  <= '0;
            go      <= 1'b0;
            done    <= 1'b0;
        end else begin
            if (reg_wr) begin
                case (reg_addr)
                    systolic_pkg::REG_W_BASE:  w_base  <= reg_wdata;
                    systolic_pkg::REG_I_BASE:  i_base  <= reg_wdata;
                    systolic_pkg::REG_K_DEPTH: k_depth <= reg_wdata;
                    systolic_pkg::REG_O_BASE:  o_base  <= reg_wdata;
                    systolic_pkg::REG_QSHIFT:  qshift  <= reg_wdata;
                    systolic_pkg::REG_CTRL: begin
                        // a go while busy is ignored
                        if (reg_wdata[0] && !go) begin
                            go   <= 1'b1;
                            done <= 1'b0;
                        end
                    end
                    default: ;
                endcase
            end
            if (run_done) begin  // end of run from the controller
                go   <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    // read data one cycle after the address
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_rdata <= '0;
        end else if (!reg_wr) begin
            case (reg_addr)
                systolic_pkg::REG_W_BASE:  reg_rdata <= w_base;
                systolic_pkg::REG_I_BASE:  reg_rdata <= i_base;
                systolic_pkg::REG_K_DEPTH: reg_rdata <= k_depth;
                systolic_pkg::REG_O_BASE:  reg_rdata <= o_base;
                systolic_pkg::REG_QSHIFT:  reg_rdata <= qshift;
                systolic_pkg::REG_CTRL:    reg_rdata <= {7'd0, go};
                systolic_pkg::REG_STATUS:  reg_rdata <= {7'd0, done};
                default:                   reg_rdata <= '0;
            endcase
        end
    end

endmodule

// ==== source/systolic_controller.sv ====
`include "systolic_cfg.svh"

module systolic_controller (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       go,
    input  logic [7:0]                 w_base,
    input  logic [7:0]                 i_base,
    input  logic [7:0]                 o_base,
    input  logic [7:0]                 k_depth,
    input  logic [7:0]                 qshift,
    input  logic                       w_almost_full,
    input  logic                       i_almost_full,
    input  logic                       out_ack,
    output logic                       w_rd,
    output logic [`SYS_ADDR_WIDTH-1:0] w_addr,
    output logic [`SYS_ADDR_WIDTH-1:0] i_addr,
    output logic                       out_wr,
    output logic [`SYS_ADDR_WIDTH-1:0] out_addr,
    output logic [7:0]                 out_data,
    output logic                       run_done,
    array_ctrl_if.ctrl                 ac
);

    localparam int N      = `SYS_ARRAY_SIZE;
    localparam int ADDR_W = `SYS_ADDR_WIDTH;
    localparam int IDX_W  = $clog2(N * N);

    systolic_pkg::ctrl_state_t state;
    logic [7:0]                feed_cnt;  // reads issued this run
    logic [IDX_W-1:0]          out_idx;   // row-major result index
    systolic_pkg::acc_t        sel;
    systolic_pkg::acc_t        shifted;

    assign ac.clr     = (state == systolic_pkg::IDLE) && go;
    assign ac.run     = (state == systolic_pkg::COMPUTE);
    assign ac.k_depth = k_depth;

    // one read per cycle while both FIFOs have room for it
    assign w_rd = (state == systolic_pkg::FILL || state == systolic_pkg::COMPUTE)
                  && (feed_cnt < k_depth) && !w_almost_full && !i_almost_full;

    assign w_addr   = ADDR_W'(w_base) + ADDR_W'(feed_cnt);
    assign i_addr   = ADDR_W'(i_base) + ADDR_W'(feed_cnt);
    assign out_addr = ADDR_W'(o_base) + ADDR_W'(out_idx);

    assign run_done = (state == systolic_pkg::WRITE_BACK) && out_wr && out_ack
                      && (out_idx == IDX_W'(N * N - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= systolic_pkg::IDLE;
            feed_cnt <= '0;
            out_idx  <= '0;
            out_wr   <= 1'b0;
        end else begin
            if (w_rd) begin
                feed_cnt <= feed_cnt + 1'b1;
            end
            case (state)
                systolic_pkg::IDLE: begin
                    if (go) begin
                        state    <= systolic_pkg::FILL;
                        feed_cnt <= '0;
                    end
                end
                systolic_pkg::FILL: begin
                    // start the array once fed out or the FIFOs fill up
                    if (feed_cnt == k_depth || w_almost_full || i_almost_full) begin
                        state <= systolic_pkg::COMPUTE;
                    end
                end
                systolic_pkg::COMPUTE: begin
                    if (ac.mac_count == k_depth) begin
                        state   <= systolic_pkg::WRITE_BACK;
                        out_idx <= '0;
                        out_wr  <= 1'b1;
                    end
                end
                systolic_pkg::WRITE_BACK: begin
                    if (out_wr && out_ack) begin
                        out_wr <= 1'b0;  // one idle cycle between writes
                        if (out_idx == IDX_W'(N * N - 1)) begin
                            state <= systolic_pkg::IDLE;
                        end else begin
                            out_idx <= out_idx + 1'b1;
                        end
                    end else if (!out_wr) begin
                        out_wr <= 1'b1;
                    end
                end
                default: state <= systolic_pkg::IDLE;
            endcase
        end
    end

    // arithmetic shift, then clamp to int8
    always_comb begin
        sel     = ac.results[out_idx / N][out_idx % N];
        shifted = sel >>> qshift;
        if (shifted > systolic_pkg::acc_t'(127)) begin
            out_data = 8'h7f;
        end else if (shifted < systolic_pkg::acc_t'(-128)) begin
            out_data = 8'h80;
        end else begin
            out_data = shifted[7:0];
        end
    end

    out_held_until_ack: assert property (@(posedge clk) disable iff (!rst_n)
        out_wr && !out_ack |=> out_wr && $stable(out_addr) && $stable(out_data));

endmodule

// ==== source/feed_fifo.sv ====
`include "systolic_cfg.svh"

module feed_fifo #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     empty,
    output logic     almost_full
);

    localparam int DEPTH = `SYS_FIFO_DEPTH;
    localparam int PW    = $clog2(DEPTH);

    payload_t      mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [PW:0]   count;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    assign pop_data    = mem[rd_ptr];  // head is visible before the pop
    assign empty       = (count == '0);
    assign almost_full = (count >= (PW + 1)'(DEPTH - 1)); // room for one read in flight

    no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> count != (PW + 1)'(DEPTH));

    no_pop_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> !empty);

endmodule

// ==== source/pe_array.sv ====
`include "systolic_cfg.svh"

module pe_array (
    input  logic               clk,
    input  logic               rst_n,
    input  systolic_pkg::row_t w_row,
    input  systolic_pkg::row_t i_row,
    input  logic               w_empty,
    input  logic               i_empty,
    output logic               pop,
    array_ctrl_if.array        ac
);

    localparam int N = `SYS_ARRAY_SIZE;

    systolic_pkg::operand_t a_skew [N];  // input lanes, row r delayed r cycles
    systolic_pkg::operand_t b_skew [N];  // weight lanes, column c delayed c cycles
    logic                   v_skew [N];

    systolic_pkg::operand_t a_in [N][N];
    systolic_pkg::operand_t b_in [N][N];
    logic                   v_in [N][N];
    systolic_pkg::operand_t a_q  [N][N];
    systolic_pkg::operand_t b_q  [N][N];
    logic                   v_q  [N][N];
    systolic_pkg::acc_t     acc  [N][N];
    logic [7:0]             mac_cnt;

    assign pop = ac.run && !w_empty && !i_empty;

    for (genvar l = 0; l < N; l++) begin : g_skew
        if (l == 0) begin : g_direct
            assign a_skew[l] = i_row[l];
            assign b_skew[l] = w_row[l];
            assign v_skew[l] = pop;
        end else begin : g_delay
            systolic_pkg::operand_t a_d [l];
            systolic_pkg::operand_t b_d [l];
            logic                   v_d [l];

            always_ff @(posedge clk) begin
                a_d[0] <= i_row[l];
                b_d[0] <= w_row[l];
                for (int s = 1; s < l; s++) begin
                    a_d[s] <= a_d[s-1];
                    b_d[s] <= b_d[s-1];
                end
            end

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    for (int s = 0; s < l; s++) begin
                        v_d[s] <= 1'b0;
                    end
                end else begin
                    v_d[0] <= pop;
                    for (int s = 1; s < l; s++) begin
                        v_d[s] <= v_d[s-1];
                    end
                end
            end

            assign a_skew[l] = a_d[l-1];
            assign b_skew[l] = b_d[l-1];
            assign v_skew[l] = v_d[l-1];
        end
    end

    for (genvar r = 0; r < N; r++) begin : g_row
        for (genvar c = 0; c < N; c++) begin : g_col
            systolic_pkg::acc_t a_ext;
            systolic_pkg::acc_t b_ext;

            // inputs and valid move right, weights move down
            if (c == 0) begin : g_left
                assign a_in[r][c] = a_skew[r];
                assign v_in[r][c] = v_skew[r];
            end else begin : g_mid
                assign a_in[r][c] = a_q[r][c-1];
                assign v_in[r][c] = v_q[r][c-1];
            end
            if (r == 0) begin : g_top
                assign b_in[r][c] = b_skew[c];
            end else begin : g_below
                assign b_in[r][c] = b_q[r-1][c];
            end

            assign a_ext = systolic_pkg::acc_t'(a_in[r][c]);
            assign b_ext = systolic_pkg::acc_t'(b_in[r][c]);

            always_ff @(posedge clk) begin
                a_q[r][c] <= a_in[r][c];
                b_q[r][c] <= b_in[r][c];
                if (ac.clr) begin
                    acc[r][c] <= '0;
                end else if (v_in[r][c]) begin
                    acc[r][c] <= acc[r][c] + a_ext * b_ext;
                end
            end

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    v_q[r][c] <= 1'b0;
                end else begin
                    v_q[r][c] <= v_in[r][c];
                end
            end

            assign ac.results[r][c] = acc[r][c];
        end
    end

    // bottom-right cell is the last one to finish
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mac_cnt <= '0;
        end else if (ac.clr) begin
            mac_cnt <= '0;
        end else if (v_in[N-1][N-1]) begin
            mac_cnt <= mac_cnt + 1'b1;
        end
    end

    assign ac.mac_count = mac_cnt;

    mac_within_depth: assert property (@(posedge clk) disable iff (!rst_n)
        ac.run |-> ac.mac_count <= ac.k_depth);

endmodule

// ==== source/systolic_top.sv ====
`include "systolic_cfg.svh"

module systolic_top (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic [2:0]                                 reg_addr,
    input  logic                                       reg_wr,
    input  logic [7:0]                                 reg_wdata,
    output logic [7:0]                                 reg_rdata,
    output logic                                       w_rd,
    output logic [`SYS_ADDR_WIDTH-1:0]                 w_addr,
    output logic [`SYS_ADDR_WIDTH-1:0]                 i_addr,
    input  logic [`SYS_ARRAY_SIZE*`SYS_DATA_WIDTH-1:0] w_rd_data,
    input  logic [`SYS_ARRAY_SIZE*`SYS_DATA_WIDTH-1:0] i_rd_data,
    output logic                                       out_wr,
    output logic [`SYS_ADDR_WIDTH-1:0]                 out_addr,
    output logic [7:0]                                 out_data,
    input  logic                                       out_ack
);

    logic [7:0]         w_base;
    logic [7:0]         i_base;
    logic [7:0]         o_base;
    logic [7:0]         k_depth;
    logic [7:0]         qshift;
    logic               go;
    logic               run_done;
    logic               push_d;     // read data valid this cycle
    logic               pop;
    logic               w_empty;
    logic               i_empty;
    logic               w_almost_full;
    logic               i_almost_full;
    systolic_pkg::row_t w_head;
    systolic_pkg::row_t i_head;

    array_ctrl_if ac ();

    // memories return data one cycle after w_rd
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            push_d <= 1'b0;
        end else begin
            push_d <= w_rd;
        end
    end

    config_regs config_regs_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .reg_addr  (systolic_pkg::reg_addr_t'(reg_addr)),
        .reg_wr    (reg_wr),
        .reg_wdata (reg_wdata),
        .run_done  (run_done),
        .reg_rdata (reg_rdata),
        .go        (go),
        .w_base    (w_base),
        .i_base    (i_base),
        .o_base    (o_base),
        .k_depth   (k_depth),
        .qshift    (qshift)
    );

    systolic_controller systolic_controller_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .go            (go),
        .w_base        (w_base),
        .i_base        (i_base),
        .o_base        (o_base),
        .k_depth       (k_depth),
        .qshift        (qshift),
        .w_almost_full (w_almost_full),
        .i_almost_full (i_almost_full),
        .out_ack       (out_ack),
        .w_rd          (w_rd),
        .w_addr        (w_addr),
        .i_addr        (i_addr),
        .out_wr        (out_wr),
        .out_addr      (out_addr),
        .out_data      (out_data),
        .run_done      (run_done),
        .ac            (ac.ctrl)
    );

    feed_fifo #(.payload_t(systolic_pkg::row_t)) w_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .push        (push_d),
        .push_data   (w_rd_data),
        .pop         (pop),
        .pop_data    (w_head),
        .empty       (w_empty),
        .almost_full (w_almost_full)
    );

    feed_fifo #(.payload_t(systolic_pkg::row_t)) i_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .push        (push_d),
        .push_data   (i_rd_data),
        .pop         (pop),
        .pop_data    (i_head),
        .empty       (i_empty),
        .almost_full (i_almost_full)
    );

    pe_array pe_array_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .w_row   (w_head),
        .i_row   (i_head),
        .w_empty (w_empty),
        .i_empty (i_empty),
        .pop     (pop),
        .ac      (ac.array)
    );

endmodule

// ==== sim/tb_systolic_top.sv ====
`include "systolic_cfg.svh"

module tb_systolic_top;

    localparam int N          = `SYS_ARRAY_SIZE;
    localparam int DW         = `SYS_DATA_WIDTH;
    localparam int AW         = `SYS_ADDR_WIDTH;
    localparam int MW         = N * DW;
    localparam int IW         = $clog2(N * N);
    localparam int POLL_LIMIT = 500;

    logic          clk;
    logic          rst_n     = 1'b0;
    logic [2:0]    reg_addr  = '0;
    logic          reg_wr    = 1'b0;
    logic [7:0]    reg_wdata = '0;
    logic [7:0]    reg_rdata;
    logic          w_rd;
    logic [AW-1:0] w_addr;
    logic [AW-1:0] i_addr;
    logic [MW-1:0] w_rd_data = '0;
    logic [MW-1:0] i_rd_data = '0;
    logic          out_wr;
    logic [AW-1:0] out_addr;
    logic [7:0]    out_data;
    logic          out_ack   = 1'b0;

    logic [MW-1:0] wmem [1 << AW];  // weight columns
    logic [MW-1:0] imem [1 << AW];  // input rows
    logic [7:0]    exp_tab [N * N]; // expected int8 results, row-major
    logic [31:0]   lfsr = 32'h5c9267a8;

    int    stall = 0;
    int    wr_count = 0;
    int    seen_run [N * N] = '{default: 0};
    int    run_id = 0;
    int    run_o_base = 0;
    string test_name = "";
    int    value_errors = 0;
    int    protocol_errors = 0;
    int    timeouts = 0;
    logic  af_seen = 1'b0;

    logic [IW-1:0] out_idx;
    logic          addr_ok;
    logic          seen_now;
    logic [7:0]    exp_out;
    logic          fifo_af;

    systolic_top systolic_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .reg_addr  (reg_addr),
        .reg_wr    (reg_wr),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .w_rd      (w_rd),
        .w_addr    (w_addr),
        .i_addr    (i_addr),
        .w_rd_data (w_rd_data),
        .i_rd_data (i_rd_data),
        .out_wr    (out_wr),
        .out_addr  (out_addr),
        .out_data  (out_data),
        .out_ack   (out_ack)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int b = 0; b < n; b++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [DW-1:0] random_operand(input int bits);
        logic signed [DW-1:0] op;
        op = DW'(lfsr_bits(bits)) << (DW - bits);
        return op >>> (DW - bits);  // sign extend the narrow value
    endfunction

    function automatic void fill_rows(input int base, input int count, input int bits);
        for (int a = base; a < base + count; a++) begin
            for (int l = 0; l < N; l++) begin
                wmem[a][l*DW +: DW] = random_operand(bits);
                imem[a][l*DW +: DW] = random_operand(bits);
            end
        end
    endfunction

    // reference: C[r][c] = sum_k in[k][r] * w[k][c], then shift and clamp
    function automatic void compute_expected(input int wb, input int ib, input int k,
                                             input int qs);
        int acc;
        int a;
        int b;
        int sh;
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                acc = 0;
                for (int kk = 0; kk < k; kk++) begin
                    a   = $signed(imem[ib + kk][r*DW +: DW]);
                    b   = $signed(wmem[wb + kk][c*DW +: DW]);
                    acc = acc + a * b;
                end
                sh = acc >>> qs;
                if (sh > 127) begin
                    exp_tab[r*N + c] = 8'h7f;
                end else if (sh < -128) begin
                    exp_tab[r*N + c] = 8'h80;
                end else begin
                    exp_tab[r*N + c] = 8'(sh);
                end
            end
        end
    endfunction

    // memory models, one cycle read latency
    always @(posedge clk) begin
        if (w_rd) begin
            w_rd_data <= wmem[w_addr];
            i_rd_data <= imem[i_addr];
        end
    end

    // output port: random 0..3 cycle ack stalls
    always @(posedge clk) begin
        if (!rst_n) begin
            out_ack <= 1'b0;
        end else if (out_wr && out_ack) begin
            out_ack           <= 1'b0;
            wr_count          <= wr_count + 1;
            seen_run[out_idx] <= run_id;
            stall             <= int'(lfsr_bits(2));
        end else if (out_wr) begin
            if (stall == 0) begin
                out_ack <= 1'b1;
            end else begin
                stall <= stall - 1;
            end
        end
    end

    always @(posedge clk) begin
        if (fifo_af) begin
            af_seen <= 1'b1;
        end
    end

    assign out_idx  = IW'(out_addr - AW'(run_o_base));
    assign addr_ok  = (int'(out_addr) >= run_o_base) && (int'(out_addr) < run_o_base + N * N);
    assign seen_now = (seen_run[out_idx] == run_id);
    assign exp_out  = exp_tab[out_idx];
    assign fifo_af  = systolic_top_inst.w_almost_full || systolic_top_inst.i_almost_full;

    out_value: assert property (@(posedge clk) disable iff (!rst_n)
        out_wr && out_ack && addr_ok |-> out_data == exp_out)
        else begin
            value_errors++;
            $display("FAILED %s out_data: expected %0d actual %0d", test_name,
                     $signed($sampled(exp_out)), $signed($sampled(out_data)));
        end

    out_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        out_wr && out_ack |-> addr_ok)
        else begin
            protocol_errors++;
            $display("%s: write to address %0h outside the output block", test_name,
                     $sampled(out_addr));
        end

    out_once: assert property (@(posedge clk) disable iff (!rst_n)
        out_wr && out_ack && addr_ok |-> !seen_now)
        else begin
            protocol_errors++;
            $display("%s: address %0h written twice in one run", test_name,
                     $sampled(out_addr));
        end

    out_stable: assert property (@(posedge clk) disable iff (!rst_n)
        out_wr && !out_ack |=> out_wr && $stable(out_addr) && $stable(out_data))
        else begin
            protocol_errors++;
            $display("%s: output write changed before it was acknowledged", test_name);
        end

    feed_backpressure: assert property (@(posedge clk) disable iff (!rst_n)
        !(w_rd && fifo_af))
        else begin
            protocol_errors++;
            $display("%s: memory read issued while a feed FIFO was almost full", test_name);
        end

    task automatic write_reg(input logic [2:0] addr, input logic [7:0] data);
        @(posedge clk);
        reg_addr  <= addr;
        reg_wr    <= 1'b1;
        reg_wdata <= data;
        @(posedge clk);
        reg_wr    <= 1'b0;
    endtask

    task automatic read_reg(input logic [2:0] addr, output logic [7:0] data);
        @(posedge clk);
        reg_addr <= addr;
        reg_wr   <= 1'b0;
        @(posedge clk);  // rdata registered here
        @(negedge clk);
        data = reg_rdata;
    endtask

    task automatic check_reg(input logic [2:0] addr, input logic [7:0] expected,
                             input string name);
        logic [7:0] got;
        read_reg(addr, got);
        assert (got == expected) else begin
            value_errors++;
            $display("FAILED %s: expected %02h actual %02h", name, expected, got);
        end
    endtask

    task automatic run_matrix(input string name, input int wb, input int ib, input int ob,
                              input int k, input int qs);
        logic [7:0] st;
        int         polls;
        int         start_count;
        test_name  = name;
        write_reg(systolic_pkg::REG_W_BASE, 8'(wb));
        write_reg(systolic_pkg::REG_I_BASE, 8'(ib));
        write_reg(systolic_pkg::REG_O_BASE, 8'(ob));
        write_reg(systolic_pkg::REG_K_DEPTH, 8'(k));
        write_reg(systolic_pkg::REG_QSHIFT, 8'(qs));
        compute_expected(wb, ib, k, qs);
        run_o_base  = ob;
        run_id      = run_id + 1;
        start_count = wr_count;
        write_reg(systolic_pkg::REG_CTRL, 8'h01);
        check_reg(systolic_pkg::REG_STATUS, 8'h00, {name, "_done_cleared"});
        polls = 0;
        st    = '0;
        while (!st[0] && polls < POLL_LIMIT) begin
            read_reg(systolic_pkg::REG_STATUS, st);
            polls++;
        end
        if (!st[0]) begin
            timeouts++;
            $display("%s: timed out waiting for done", name);
        end
        check_reg(systolic_pkg::REG_CTRL, 8'h00, {name, "_go_cleared"});
        assert (wr_count - start_count == N * N) else begin
            value_errors++;
            $display("FAILED %s_write_count: expected %0d actual %0d", name, N * N,
                     wr_count - start_count);
        end
    endtask

    initial begin
        fill_rows(0, 1 << AW, DW);
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        // register access
        test_name = "registers";
        check_reg(systolic_pkg::REG_STATUS, 8'h00, "reset_status");
        write_reg(systolic_pkg::REG_W_BASE, 8'h5a);
        write_reg(systolic_pkg::REG_I_BASE, 8'hc3);
        write_reg(systolic_pkg::REG_K_DEPTH, 8'h11);
        write_reg(systolic_pkg::REG_O_BASE, 8'h7e);
        write_reg(systolic_pkg::REG_QSHIFT, 8'h03);
        write_reg(systolic_pkg::REG_STATUS, 8'hff);  // read only
        check_reg(systolic_pkg::REG_W_BASE, 8'h5a, "w_base_readback");
        check_reg(systolic_pkg::REG_I_BASE, 8'hc3, "i_base_readback");
        check_reg(systolic_pkg::REG_K_DEPTH, 8'h11, "k_depth_readback");
        check_reg(systolic_pkg::REG_O_BASE, 8'h7e, "o_base_readback");
        check_reg(systolic_pkg::REG_QSHIFT, 8'h03, "qshift_readback");
        check_reg(systolic_pkg::REG_STATUS, 8'h00, "status_read_only");
        check_reg(systolic_pkg::REG_CTRL, 8'h00, "ctrl_idle");

        // small operands, no shift
        fill_rows(8'h10, 4, 3);
        fill_rows(8'h40, 4, 3);
        run_matrix("matrix_product", 8'h10, 8'h40, 8'h20, 4, 0);
        check_reg(systolic_pkg::REG_STATUS, 8'h01, "matrix_product_done");

        // large operands, lanes forced so (0,0) clamps high and (0,1) clamps low
        fill_rows(8'h80, 6, DW);
        fill_rows(8'ha0, 6, DW);
        for (int k = 0; k < 6; k++) begin
            imem[8'ha0 + k][0 +: DW]  = 8'sd127;
            wmem[8'h80 + k][0 +: DW]  = 8'sd127;
            wmem[8'h80 + k][DW +: DW] = 8'h80;
        end
        run_matrix("quantization", 8'h80, 8'ha0, 8'h50, 6, 4);
        check_reg(systolic_pkg::REG_STATUS, 8'h01, "quantization_done");

        // deeper than the FIFOs, second run with new bases
        fill_rows(8'hc0, 20, 4);
        fill_rows(8'h30, 20, 4);
        run_matrix("feed_backpressure", 8'hc0, 8'h30, 8'h90, 20, 2);
        check_reg(systolic_pkg::REG_STATUS, 8'h01, "feed_backpressure_done");
        assert (af_seen) else begin
            protocol_errors++;
            $display("feed_backpressure: the feed FIFOs never reached almost full");
        end

        $display("errors: value %0d, protocol %0d, timeout %0d",
                 value_errors, protocol_errors, timeouts);
        if (value_errors == 0 && protocol_errors == 0 && timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+source
source/systolic_pkg.sv
source/array_ctrl_if.sv
source/config_regs.sv
source/systolic_controller.sv
source/feed_fifo.sv
source/pe_array.sv
source/systolic_top.sv
sim/tb_systolic_top.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = tb_systolic_top
FILELIST = sources.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with $(TOOL) and run $(TOP)"
	@echo "  clean  remove the build directory"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir
